// File: source/rv_backend_pkg.sv
package rv_backend_pkg;

    // ALU operations of the RV32I integer subset
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_e;

    // Data memory access kind
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } mem_op_e;

    // Writeback source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2,
        WB_IMM = 2'd3
    } wb_sel_e;

    // Decoded instruction, operands already read
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic        use_imm;   // Second ALU operand is imm
        alu_op_e     alu_op;
        mem_op_e     mem_op;
        wb_sel_e     wb_sel;
        logic        we;
        logic [4:0]  rd;
    } ex_bundle_t;

    // Execute result heading into the memory stage
    typedef struct packed {
        logic [31:0] alu_res;   // Also the byte address for loads/stores
        logic [31:0] st_data;
        logic [31:0] imm;
        logic [31:0] link;      // pc + 4
        mem_op_e     mem_op;
        wb_sel_e     wb_sel;
        logic        we;
        logic [4:0]  rd;
    } mem_bundle_t;

    // Register file write port
    typedef struct packed {
        logic        en;
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

// File: source/stage_reg.sv
`timescale 1ns/100ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     stall_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    // Valid bit is the only control state here
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

    // Payload frozen while memory is busy
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            data_o <= data_i;
        end
    end

endmodule

// File: source/exec_stage.sv
`timescale 1ns/100ps

module exec_stage (
    input  rv_backend_pkg::ex_bundle_t  ex_i,
    input  logic                        valid_i,
    output rv_backend_pkg::mem_bundle_t mem_o,
    output logic                        valid_o
);
    import rv_backend_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] alu_res;

    assign op_a  = ex_i.rs1;
    assign op_b  = ex_i.use_imm ? ex_i.imm : ex_i.rs2;
    assign shamt = op_b[4:0];   // Only the low five bits shift

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD: begin
                alu_res = op_a + op_b;
            end
            ALU_SUB: begin
                alu_res = op_a - op_b;
            end
            ALU_AND: begin
                alu_res = op_a & op_b;
            end
            ALU_OR: begin
                alu_res = op_a | op_b;
            end
            ALU_XOR: begin
                alu_res = op_a ^ op_b;
            end
            ALU_SLL: begin
                alu_res = op_a << shamt;
            end
            ALU_SRL: begin
                alu_res = op_a >> shamt;
            end
            ALU_SRA: begin
                alu_res = $unsigned($signed(op_a) >>> shamt);
            end
            ALU_SLT: begin
                alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            end
            ALU_SLTU: begin
                alu_res = {31'd0, op_a < op_b};
            end
            default: begin
                alu_res = op_a + op_b;
            end
        endcase
    end

    always_comb begin
        mem_o.alu_res = alu_res;
        mem_o.st_data = ex_i.rs2;           // Stores always take rs2
        mem_o.imm     = ex_i.imm;
        mem_o.link    = ex_i.pc + 32'd4;
        mem_o.mem_op  = ex_i.mem_op;
        mem_o.wb_sel  = ex_i.wb_sel;
        mem_o.we      = ex_i.we;
        mem_o.rd      = ex_i.rd;
    end

    // No internal state, so validity passes straight on
    assign valid_o = valid_i;

endmodule

// File: source/data_mem.sv
`timescale 1ns/100ps

module data_mem #(
    parameter int unsigned MEM_WORDS   = 256,
    parameter int unsigned MEM_LATENCY = 2
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         req_i,
    input  logic                         we_i,
    input  logic [$clog2(MEM_WORDS)-1:0] addr_i,
    input  logic [31:0]                  wdata_i,
    input  logic [3:0]                   be_i,
    output logic [31:0]                  rdata_o,
    output logic                         busywait_o
);

    // Wide enough to count up to MEM_LATENCY
    localparam int unsigned CW = (MEM_LATENCY > 0) ? $clog2(MEM_LATENCY + 1) : 1;
    localparam logic [CW-1:0] LAST = CW'(MEM_LATENCY);

    logic [31:0]   mem [MEM_WORDS];
    logic [CW-1:0] cnt;
    logic          done;

    // Access completes once the counter has run out
    assign done       = req_i && (cnt == LAST);
    assign busywait_o = req_i && !done;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt <= '0;
        end else if (busywait_o) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;      // Ready for the next request
        end
    end

    // Byte lane writes on the completing cycle
    always_ff @(posedge clk_i) begin
        if (done && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Read word valid only while the load completes
    assign rdata_o = (done && !we_i) ? mem[addr_i] : 32'd0;

endmodule

// File: source/mem_stage.sv
`timescale 1ns/100ps

module mem_stage #(
    parameter int unsigned MEM_WORDS   = 256,
    parameter int unsigned MEM_LATENCY = 2
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  rv_backend_pkg::mem_bundle_t mem_i,
    input  logic                        valid_i,
    output rv_backend_pkg::wb_t         wb_o,
    output logic                        wb_valid_o,
    output logic                        busywait_o
);
    import rv_backend_pkg::*;

    localparam int unsigned AW = $clog2(MEM_WORDS);

    logic          req;
    logic          is_store;
    logic [AW-1:0] addr;
    logic [1:0]    byte_off;
    logic [31:0]   wdata;
    logic [3:0]    be;
    logic [31:0]   rdata;
    logic [31:0]   rshift;
    logic [31:0]   load_data;
    logic [31:0]   wb_data;
    logic          wr_en;

    assign byte_off = mem_i.alu_res[1:0];
    assign addr     = mem_i.alu_res[AW+1:2];    // Upper address bits wrap

    assign is_store = (mem_i.mem_op == MEM_SB) || (mem_i.mem_op == MEM_SH) ||
                      (mem_i.mem_op == MEM_SW);

    // Bubbles never reach the memory
    assign req   = valid_i && (mem_i.mem_op != MEM_NONE);
    assign wdata = mem_i.st_data << {byte_off, 3'b000};

    // Accesses assumed naturally aligned
    always_comb begin
        case (mem_i.mem_op)
            MEM_SB:  be = 4'b0001 << byte_off;
            MEM_SH:  be = 4'b0011 << byte_off;
            MEM_SW:  be = 4'b1111;
            default: be = 4'b0000;
        endcase
    end

    data_mem #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_data_mem (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .req_i      (req),
        .we_i       (is_store),
        .addr_i     (addr),
        .wdata_i    (wdata),
        .be_i       (be),
        .rdata_o    (rdata),
        .busywait_o (busywait_o)
    );

    // Addressed byte or half moved down to bit 0
    assign rshift = rdata >> {byte_off, 3'b000};

    always_comb begin
        case (mem_i.mem_op)
            MEM_LB:  load_data = {{24{rshift[7]}}, rshift[7:0]};
            MEM_LH:  load_data = {{16{rshift[15]}}, rshift[15:0]};
            MEM_LBU: load_data = {24'd0, rshift[7:0]};
            MEM_LHU: load_data = {16'd0, rshift[15:0]};
            default: load_data = rshift;    // LW
        endcase
    end

    always_comb begin
        case (mem_i.wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_PC4:  wb_data = mem_i.link;
            WB_IMM:  wb_data = mem_i.imm;
            default: wb_data = mem_i.alu_res;
        endcase
    end

    // x0 writes and stores are dropped here
    assign wr_en = mem_i.we && (mem_i.rd != 5'd0) && !is_store;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= valid_i && wr_en && !busywait_o;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!busywait_o) begin
            wb_o.en   <= wr_en;
            wb_o.rd   <= mem_i.rd;
            wb_o.data <= wb_data;
        end
    end

endmodule

// File: source/rv_backend.sv
`timescale 1ns/100ps

module rv_backend #(
    parameter int unsigned MEM_WORDS   = 256,
    parameter int unsigned MEM_LATENCY = 2
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  rv_backend_pkg::ex_bundle_t inst_i,
    input  logic                       inst_valid_i,
    output logic                       stall_o,
    output rv_backend_pkg::wb_t        wb_o,
    output logic                       wb_valid_o
);
    import rv_backend_pkg::*;

    ex_bundle_t  ex_q;
    logic        ex_valid_q;
    mem_bundle_t mem_d;
    logic        mem_valid_d;
    mem_bundle_t mem_q;
    logic        mem_valid_q;
    logic        busywait;

    assign stall_o = busywait;  // One stall for the whole pipe

    stage_reg #(
        .payload_t (ex_bundle_t)
    ) u_in_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stall_i (busywait),
        .valid_i (inst_valid_i),
        .data_i  (inst_i),
        .valid_o (ex_valid_q),
        .data_o  (ex_q)
    );

    exec_stage u_exec (
        .ex_i    (ex_q),
        .valid_i (ex_valid_q),
        .mem_o   (mem_d),
        .valid_o (mem_valid_d)
    );

    stage_reg #(
        .payload_t (mem_bundle_t)
    ) u_ex_mem_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stall_i (busywait),
        .valid_i (mem_valid_d),
        .data_i  (mem_d),
        .valid_o (mem_valid_q),
        .data_o  (mem_q)
    );

    mem_stage #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_mem (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .mem_i      (mem_q),
        .valid_i    (mem_valid_q),
        .wb_o       (wb_o),
        .wb_valid_o (wb_valid_o),
        .busywait_o (busywait)
    );

endmodule

// File: testbench/rv_backend_model.svh
`ifndef RV_BACKEND_MODEL_SVH
`define RV_BACKEND_MODEL_SVH

// Shadow copy of the data memory
logic [31:0] shadow_mem [MEM_WORDS];

function automatic logic is_store_op(input mem_op_e op);
    return (op == MEM_SB) || (op == MEM_SH) || (op == MEM_SW);
endfunction

function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] r;
    logic [4:0]  sh;
    sh = b[4:0];
    case (op)
        ALU_ADD:  r = a + b;
        ALU_SUB:  r = a + ~b + 32'd1;     // Two's complement subtract
        ALU_AND:  r = a & b;
        ALU_OR:   r = a | b;
        ALU_XOR:  r = a ^ b;
        ALU_SLL:  r = a << sh;
        ALU_SRL:  r = a >> sh;
        ALU_SRA: begin
            r = a >> sh;
            if (a[31]) begin
                r = r | ~(32'hffff_ffff >> sh);   // Refill vacated top bits
            end
        end
        ALU_SLT:  r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
        ALU_SLTU: r = {31'd0, a < b};
        default:  r = 32'hxxxx_xxxx;
    endcase
    return r;
endfunction

function automatic int unsigned word_index(input logic [31:0] addr);
    return (addr >> 2) % MEM_WORDS;       // Upper bits wrap like the DUT
endfunction

task automatic shadow_store(input mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] data);
    int unsigned idx;
    int unsigned nbytes;
    int unsigned lane;
    idx    = word_index(addr);
    nbytes = (op == MEM_SB) ? 1 : ((op == MEM_SH) ? 2 : 4);
    for (int i = 0; i < nbytes; i++) begin
        lane = addr[1:0] + i;
        shadow_mem[idx][8*lane +: 8] = data[8*i +: 8];
    end
endtask

function automatic logic [31:0] load_model(input mem_op_e op, input logic [31:0] addr);
    logic [31:0] word;
    logic [7:0]  b;
    logic [15:0] h;
    word = shadow_mem[word_index(addr)];
    b    = word[8*addr[1:0] +: 8];
    h    = addr[1] ? word[31:16] : word[15:0];
    case (op)
        MEM_LB:  return {{24{b[7]}}, b};
        MEM_LBU: return {24'd0, b};
        MEM_LH:  return {{16{h[15]}}, h};
        MEM_LHU: return {16'd0, h};
        default: return word;
    endcase
endfunction

// Value the write port should carry for an accepted bundle
function automatic logic [31:0] expected_data(input ex_bundle_t b);
    logic [31:0] res;
    res = alu_model(b.alu_op, b.rs1, b.use_imm ? b.imm : b.rs2);
    case (b.wb_sel)
        WB_MEM:  return load_model(b.mem_op, res);
        WB_PC4:  return b.pc + 32'd4;
        WB_IMM:  return b.imm;
        default: return res;
    endcase
endfunction

function automatic logic writes_back(input ex_bundle_t b);
    return b.we && (b.rd != 5'd0) && !is_store_op(b.mem_op);
endfunction

`endif

// File: testbench/rv_backend_tb.sv
`timescale 1ns/100ps

module rv_backend_tb;
    import rv_backend_pkg::*;

    localparam int unsigned MEM_WORDS   = 256;
    localparam int unsigned MEM_LATENCY = 2;
    localparam logic [31:0] WIN_BASE    = 32'h0000_0400;  // Eight-word load/store window
    localparam int unsigned N_INST      = 182;
    localparam int unsigned WATCHDOG_NS = N_INST * (3 + MEM_LATENCY) * 20 + 2000;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        logic        timed;     // Fixed three-edge latency expected
        logic [31:0] cycle;     // Accepting edge
    } exp_wr_t;

    logic        clk = 1'b0;
    logic        rst;
    ex_bundle_t  inst;
    logic        inst_valid;
    logic        stall;
    wb_t         wb;
    logic        wb_valid;

    logic [31:0] rng_state;
    logic [31:0] cycle_cnt = '0;
    exp_wr_t     exp_q[$];
    string       test_name;
    int          checks;
    int          errors;
    int          test_checks;
    int          test_errors;
    int          n_tests;
    int          stall_cycles;
    logic        timed_mode;

    `include "rv_backend_model.svh"

    rv_backend #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) dut0 (
        .clk_i        (clk),
        .rst_i        (rst),
        .inst_i       (inst),
        .inst_valid_i (inst_valid),
        .stall_o      (stall),
        .wb_o         (wb),
        .wb_valid_o   (wb_valid)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic ex_bundle_t alu_inst(input alu_op_e op, input logic use_imm);
        ex_bundle_t  b;
        logic [31:0] r;
        r         = rand32();
        b.pc      = rand32() & ~32'd3;
        b.rs1     = rand32();
        b.rs2     = rand32();
        b.imm     = {{20{r[11]}}, r[11:0]};   // I-type style immediate
        b.use_imm = use_imm;
        b.alu_op  = op;
        b.mem_op  = MEM_NONE;
        b.wb_sel  = WB_ALU;
        b.we      = 1'b1;
        b.rd      = (r[16:12] == 5'd0) ? 5'd1 : r[16:12];
        return b;
    endfunction

    function automatic ex_bundle_t mem_inst(input mem_op_e op);
        ex_bundle_t  b;
        logic [31:0] addr;
        logic [31:0] r;
        b    = alu_inst(ALU_ADD, 1'b1);
        r    = rand32();
        addr = WIN_BASE + (r & 32'h0000_001f);
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: addr[0] = 1'b0;
            MEM_LW, MEM_SW:          addr[1:0] = 2'b00;
            default: ;
        endcase
        b.rs1    = WIN_BASE + (rand32() & 32'h0000_003c);
        b.imm    = addr - b.rs1;
        b.mem_op = op;
        b.wb_sel = is_store_op(op) ? WB_ALU : WB_MEM;
        b.we     = is_store_op(op) ? r[8] : 1'b1;   // Write flag random on stores
        return b;
    endfunction

    // Every reported write must match the oldest outstanding one
    always @(posedge clk) begin : write_monitor
        exp_wr_t head;
        cycle_cnt <= cycle_cnt + 1;
        if (!rst && stall) begin
            stall_cycles++;
        end
        if (!rst && wb_valid) begin
            checks++;
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("%s: write to x%0d appeared with no instruction pending",
                         test_name, wb.rd);
            end
            if (exp_q.size() > 0) begin
                head = exp_q.pop_front();
                assert (wb.en && wb.rd == head.rd && wb.data == head.data) else begin
                    errors++;
                    $display("Error: %s expected x%0d=%h actual x%0d=%h",
                             test_name, head.rd, head.data, wb.rd, wb.data);
                end
                if (head.timed) begin
                    assert (cycle_cnt - head.cycle == 32'd3) else begin
                        errors++;
                        $display("Error: %s latency expected 3 actual %0d",
                                 test_name, cycle_cnt - head.cycle);
                    end
                end
            end
        end
    end

    // Present one instruction and hold it until the pipeline takes it
    task automatic issue(input ex_bundle_t b);
        exp_wr_t e;
        inst       = b;
        inst_valid = 1'b1;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
        if (writes_back(b)) begin
            e.rd    = b.rd;
            e.data  = expected_data(b);
            e.timed = timed_mode;
            e.cycle = cycle_cnt;
            exp_q.push_back(e);
        end
        if (is_store_op(b.mem_op)) begin
            shadow_store(b.mem_op, alu_model(b.alu_op, b.rs1, b.imm), b.rs2);
        end
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        checks++;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%s: %0d expected writes never arrived", test_name, exp_q.size());
        end
        repeat (5) @(posedge clk);    // Room for a duplicate to show up
        #1;
    endtask

    task automatic begin_test(input string name, input logic timed);
        test_name   = name;
        timed_mode  = timed;
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test();
        n_tests++;
        $display("%s: %0d checks, %0d errors", test_name, checks - test_checks,
                 errors - test_errors);
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the pipeline stopped making progress",
                 WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : main_seq
        ex_bundle_t  b;
        logic [31:0] r;
        inst         = '0;
        inst_valid   = 1'b0;
        rst          = 1'b1;
        rng_state    = 32'h985d;
        checks       = 0;
        errors       = 0;
        n_tests      = 0;
        stall_cycles = 0;
        timed_mode   = 1'b0;
        test_name    = "reset";
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("reset", 1'b0);
        repeat (4) begin
            @(posedge clk);
            checks++;
            assert (!wb_valid && !stall) else begin
                errors++;
                $display("Error: %s wb_valid/stall expected 0/0 actual %b/%b",
                         test_name, wb_valid, stall);
            end
        end
        #1;
        end_test();

        begin_test("alu_ops", 1'b1);
        for (int op = 0; op < 10; op++) begin
            for (int k = 0; k < 6; k++) begin
                issue(alu_inst(alu_op_e'(op[3:0]), k[0]));
            end
        end
        drain();
        end_test();

        // Silent instructions sit between real writes, so a stray one breaks ordering
        begin_test("wb_select", 1'b1);
        for (int k = 0; k < 14; k++) begin
            b = alu_inst(ALU_ADD, 1'b0);
            case (k % 4)
                0:       b.wb_sel = WB_IMM;
                1:       b.wb_sel = WB_PC4;
                2:       b.rd = 5'd0;
                default: b.we = 1'b0;
            endcase
            issue(b);
        end
        drain();
        end_test();

        begin_test("load_store", 1'b0);
        for (int w = 0; w < 8; w++) begin
            b     = mem_inst(MEM_SW);
            b.imm = WIN_BASE + 32'(w * 4) - b.rs1;   // Whole window defined first
            issue(b);
        end
        for (int k = 0; k < 40; k++) begin
            r = rand32();
            issue(mem_inst(mem_op_e'(4'd1 + {1'b0, r[2:0]})));
        end
        drain();
        end_test();

        begin_test("backpressure", 1'b0);
        stall_cycles = 0;
        for (int k = 0; k < 60; k++) begin
            r = rand32();
            if (r[1:0] == 2'd0) begin
                issue(mem_inst(mem_op_e'(4'd1 + {1'b0, r[4:2]})));
            end else begin
                issue(alu_inst(alu_op_e'(4'(r[31:8] % 10)), r[5]));
            end
        end
        drain();
        checks++;
        assert (stall_cycles > 0) else begin
            errors++;
            $display("%s: stall_o never rose although memory ops were issued", test_name);
        end
        end_test();

        $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: rv_backend.f
+incdir+testbench
source/rv_backend_pkg.sv
source/stage_reg.sv
source/exec_stage.sv
source/data_mem.sv
source/mem_stage.sv
source/rv_backend.sv
testbench/rv_backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rv_backend testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module rv_backend_tb \
    -f rv_backend.f -o rv_backend_sim > build.log 2>&1 &&
./obj_dir/rv_backend_sim > sim.log 2>&1 &&
grep -q "^TEST OK$" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
